/* src/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [4:0]  shamt_t;

    localparam int TAG_W_DEFAULT = 4;

    // funct7 values that select the base set, the alternate ops and the M extension
    localparam funct7_t F7_BASE   = 7'b0000000;
    localparam funct7_t F7_ALT    = 7'b0100000;
    localparam funct7_t F7_MULDIV = 7'b0000001;

    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU,
        OP_ILLEGAL
    } alu_op_t;

    typedef struct packed {
        logic    is_imm;
        funct7_t funct7;
        funct3_t funct3;
        word_t   op1;
        word_t   op2;
    } alu_req_t;

    typedef struct packed {
        alu_op_t op;
        word_t   op1;
        word_t   op2;
    } alu_dec_t;

    typedef struct packed {
        word_t result;
        logic  illegal;
    } alu_rsp_t;

endpackage

`default_nettype wire

/* src/alu_decode.sv */
`default_nettype none

module alu_decode #(
    parameter int TAG_W = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  alu_pkg::alu_req_t  req,
    input  logic [TAG_W-1:0]   in_tag,
    output logic               dec_valid,
    output alu_pkg::alu_dec_t  dec,
    output logic [TAG_W-1:0]   dec_tag
);

    alu_pkg::alu_op_t op_next;

    always_comb begin
        op_next = alu_pkg::OP_ILLEGAL;
        if (req.is_imm) begin
            // Only the shift immediates carry a funct7 field
            case (req.funct3)
                3'b000: op_next = alu_pkg::OP_ADD;
                3'b010: op_next = alu_pkg::OP_SLT;
                3'b011: op_next = alu_pkg::OP_SLTU;
                3'b100: op_next = alu_pkg::OP_XOR;
                3'b110: op_next = alu_pkg::OP_OR;
                3'b111: op_next = alu_pkg::OP_AND;
                3'b001: begin
                    if (req.funct7 == alu_pkg::F7_BASE) begin
                        op_next = alu_pkg::OP_SLL;
                    end
                end
                default: begin
                    if (req.funct7 == alu_pkg::F7_BASE) begin
                        op_next = alu_pkg::OP_SRL;
                    end else if (req.funct7 == alu_pkg::F7_ALT) begin
                        op_next = alu_pkg::OP_SRA;
                    end
                end
            endcase
        end else begin
            case (req.funct7)
                alu_pkg::F7_BASE: begin
                    case (req.funct3)
                        3'b000:  op_next = alu_pkg::OP_ADD;
                        3'b001:  op_next = alu_pkg::OP_SLL;
                        3'b010:  op_next = alu_pkg::OP_SLT;
                        3'b011:  op_next = alu_pkg::OP_SLTU;
                        3'b100:  op_next = alu_pkg::OP_XOR;
                        3'b101:  op_next = alu_pkg::OP_SRL;
                        3'b110:  op_next = alu_pkg::OP_OR;
                        default: op_next = alu_pkg::OP_AND;
                    endcase
                end
                alu_pkg::F7_ALT: begin
                    if (req.funct3 == 3'b000) begin
                        op_next = alu_pkg::OP_SUB;
                    end else if (req.funct3 == 3'b101) begin
                        op_next = alu_pkg::OP_SRA;
                    end
                end
                alu_pkg::F7_MULDIV: begin
                    case (req.funct3)
                        3'b000:  op_next = alu_pkg::OP_MUL;
                        3'b001:  op_next = alu_pkg::OP_MULH;
                        3'b010:  op_next = alu_pkg::OP_MULHSU;
                        3'b011:  op_next = alu_pkg::OP_MULHU;
                        3'b100:  op_next = alu_pkg::OP_DIV;
                        3'b101:  op_next = alu_pkg::OP_DIVU;
                        3'b110:  op_next = alu_pkg::OP_REM;
                        default: op_next = alu_pkg::OP_REMU;
                    endcase
                end
                default: op_next = alu_pkg::OP_ILLEGAL;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec.op  <= op_next;
            dec.op1 <= req.op1;
            dec.op2 <= req.op2;
            dec_tag <= in_tag;
        end
    end

endmodule

`default_nettype wire

/* src/alu_mul.sv */
`default_nettype none

module alu_mul (
    input  alu_pkg::alu_op_t op,
    input  alu_pkg::word_t   op1,
    input  alu_pkg::word_t   op2,
    output alu_pkg::word_t   product_lo,
    output alu_pkg::word_t   product_hi
);

    logic               op1_signed;
    logic               op2_signed;
    logic signed [32:0] op1_ext;
    logic signed [32:0] op2_ext;
    logic signed [65:0] product;

    // MULHSU treats op2 as unsigned and MULHU treats both as unsigned
    always_comb begin
        op1_signed = (op == alu_pkg::OP_MUL) || (op == alu_pkg::OP_MULH) ||
                     (op == alu_pkg::OP_MULHSU);
        op2_signed = (op == alu_pkg::OP_MUL) || (op == alu_pkg::OP_MULH);
    end

    assign op1_ext = {op1_signed & op1[31], op1};
    assign op2_ext = {op2_signed & op2[31], op2};

    // A 33 bit signed product covers every signedness combination
    assign product = op1_ext * op2_ext;

    assign product_lo = product[31:0];
    assign product_hi = product[63:32];

endmodule

`default_nettype wire

/* src/alu_div.sv */
`default_nettype none

module alu_div (
    input  alu_pkg::alu_op_t op,
    input  alu_pkg::word_t   op1,
    input  alu_pkg::word_t   op2,
    output alu_pkg::word_t   quotient,
    output alu_pkg::word_t   remainder
);

    localparam alu_pkg::word_t WORD_MIN = 32'h8000_0000;

    logic is_signed;
    logic div_zero;
    logic overflow;

    assign is_signed = (op == alu_pkg::OP_DIV) || (op == alu_pkg::OP_REM);
    assign div_zero  = (op2 == '0);

    // Only the signed form can overflow, on the most negative number over minus one
    assign overflow  = is_signed && (op1 == WORD_MIN) && (op2 == '1);

    always_comb begin
        // Division by zero leaves all ones and the dividend
        quotient  = '1;
        remainder = op1;
        if (!div_zero) begin
            if (overflow) begin
                quotient  = op1;
                remainder = '0;
            end else if (is_signed) begin
                quotient  = $signed(op1) / $signed(op2);
                remainder = $signed(op1) % $signed(op2);
            end else begin
                quotient  = op1 / op2;
                remainder = op1 % op2;
            end
        end
    end

endmodule

`default_nettype wire

/* src/alu_exec.sv */
`default_nettype none

module alu_exec #(
    parameter int TAG_W = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               dec_valid,
    input  alu_pkg::alu_dec_t  dec,
    input  logic [TAG_W-1:0]   dec_tag,
    output logic               out_valid,
    output alu_pkg::alu_rsp_t  rsp,
    output logic [TAG_W-1:0]   out_tag
);

    alu_pkg::word_t    sum;
    alu_pkg::word_t    diff;
    alu_pkg::shamt_t   shamt;
    logic              lt_signed;
    logic              lt_unsigned;
    alu_pkg::word_t    product_lo;
    alu_pkg::word_t    product_hi;
    alu_pkg::word_t    quotient;
    alu_pkg::word_t    remainder;
    alu_pkg::alu_rsp_t rsp_next;

    alu_mul i_alu_mul (
        .op         (dec.op),
        .op1        (dec.op1),
        .op2        (dec.op2),
        .product_lo (product_lo),
        .product_hi (product_hi)
    );

    alu_div i_alu_div (
        .op        (dec.op),
        .op1       (dec.op1),
        .op2       (dec.op2),
        .quotient  (quotient),
        .remainder (remainder)
    );

    assign sum         = dec.op1 + dec.op2;
    assign diff        = dec.op1 - dec.op2;
    assign shamt       = dec.op2[4:0];
    assign lt_signed   = $signed(dec.op1) < $signed(dec.op2);
    assign lt_unsigned = dec.op1 < dec.op2;

    always_comb begin
        rsp_next.illegal = 1'b0;
        case (dec.op)
            alu_pkg::OP_ADD:    rsp_next.result = sum;
            alu_pkg::OP_SUB:    rsp_next.result = diff;
            alu_pkg::OP_SLL:    rsp_next.result = dec.op1 << shamt;
            alu_pkg::OP_SLT:    rsp_next.result = {31'b0, lt_signed};
            alu_pkg::OP_SLTU:   rsp_next.result = {31'b0, lt_unsigned};
            alu_pkg::OP_XOR:    rsp_next.result = dec.op1 ^ dec.op2;
            alu_pkg::OP_SRL:    rsp_next.result = dec.op1 >> shamt;
            alu_pkg::OP_SRA:    rsp_next.result = $signed(dec.op1) >>> shamt;
            alu_pkg::OP_OR:     rsp_next.result = dec.op1 | dec.op2;
            alu_pkg::OP_AND:    rsp_next.result = dec.op1 & dec.op2;
            alu_pkg::OP_MUL:    rsp_next.result = product_lo;
            alu_pkg::OP_MULH,
            alu_pkg::OP_MULHSU,
            alu_pkg::OP_MULHU:  rsp_next.result = product_hi;
            alu_pkg::OP_DIV,
            alu_pkg::OP_DIVU:   rsp_next.result = quotient;
            alu_pkg::OP_REM,
            alu_pkg::OP_REMU:   rsp_next.result = remainder;
            default: begin
                // Unknown encodings return zero and flag the request
                rsp_next.result  = '0;
                rsp_next.illegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            rsp     <= rsp_next;
            out_tag <= dec_tag;
        end
    end

endmodule

`default_nettype wire

/* src/alu_pipe_top.sv */
`default_nettype none

module alu_pipe_top #(
    parameter int TAG_W = alu_pkg::TAG_W_DEFAULT
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  alu_pkg::alu_req_t  req,
    input  logic [TAG_W-1:0]   in_tag,
    output logic               out_valid,
    output alu_pkg::alu_rsp_t  rsp,
    output logic [TAG_W-1:0]   out_tag
);

    // Stage 1 to stage 2
    logic              dec_valid;
    alu_pkg::alu_dec_t dec;
    logic [TAG_W-1:0]  dec_tag;

    alu_decode #(
        .TAG_W (TAG_W)
    ) i_alu_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .req       (req),
        .in_tag    (in_tag),
        .dec_valid (dec_valid),
        .dec       (dec),
        .dec_tag   (dec_tag)
    );

    alu_exec #(
        .TAG_W (TAG_W)
    ) i_alu_exec (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec       (dec),
        .dec_tag   (dec_tag),
        .out_valid (out_valid),
        .rsp       (rsp),
        .out_tag   (out_tag)
    );

endmodule

`default_nettype wire

/* tests/alu_pipe_assert.sv */
`default_nettype none

module alu_pipe_assert (
    input logic              clk,
    input logic              arst_n,
    input logic              in_valid,
    input logic              out_valid,
    input alu_pkg::alu_rsp_t rsp
);

    // Each accepted request returns exactly two cycles later
    assert property (@(posedge clk) disable iff (!arst_n) $past(in_valid, 2) |-> out_valid)
        else $error("out_valid did not follow in_valid after two cycles");

    assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid is high during reset");

    assert property (@(posedge clk) disable iff (!arst_n)
                     out_valid && rsp.illegal |-> rsp.result == '0)
        else $error("Illegal response carries a nonzero result");

    // No response may appear without a request two cycles before
    assert property (@(posedge clk) disable iff (!arst_n) out_valid |-> $past(in_valid, 2))
        else $error("out_valid without a matching in_valid");

endmodule

bind alu_pipe_top alu_pipe_assert i_alu_pipe_assert (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .rsp       (rsp)
);

`default_nettype wire

/* tests/tb_alu_pipe.sv */
`default_nettype none

module tb_alu_pipe;

    localparam int TAG_W       = 4;
    localparam int CLK_HALF    = 20;
    localparam int DRIVE_DLY   = 2;
    localparam int MAX_GAP     = 2;
    localparam int DRAIN_LIMIT = 20;

    typedef struct packed {
        alu_pkg::alu_rsp_t rsp;
        logic [TAG_W-1:0]  tag;
        // Cycle in which the response must come out
        int                due;
    } expect_t;

    logic              clk;
    logic              arst_n;
    logic              in_valid;
    alu_pkg::alu_req_t req;
    logic [TAG_W-1:0]  in_tag;
    logic              out_valid;
    alu_pkg::alu_rsp_t rsp;
    logic [TAG_W-1:0]  out_tag;

    expect_t exp_q[$];
    int      n_checked;
    int      cycle_cnt;

    alu_pipe_top #(
        .TAG_W (TAG_W)
    ) i_alu_pipe_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .req       (req),
        .in_tag    (in_tag),
        .out_valid (out_valid),
        .rsp       (rsp),
        .out_tag   (out_tag)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic report_error(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_result(input alu_pkg::word_t got, input alu_pkg::word_t exp);
        if (got !== exp) begin
            report_error($sformatf("FAILED at %0t: rsp.result is %h, expected %h",
                                   $time, got, exp));
        end
    endtask

    task automatic check_illegal(input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("FAILED at %0t: rsp.illegal is %b, expected %b",
                                   $time, got, exp));
        end
    endtask

    task automatic check_tag(input logic [TAG_W-1:0] got, input logic [TAG_W-1:0] exp);
        if (got !== exp) begin
            report_error($sformatf("FAILED at %0t: out_tag is %h, expected %h",
                                   $time, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            report_error($sformatf("FAILED at %0t: out_valid came in cycle %0d, expected %0d",
                                   $time, got, exp));
        end
    endtask

    // Responses are stable for the whole cycle, so look at them on the falling edge
    always @(negedge clk) begin
        expect_t e;
        if (arst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                report_error("A response came out while no request was outstanding");
            end else begin
                e = exp_q.pop_front();
                check_result(rsp.result, e.rsp.result);
                check_illegal(rsp.illegal, e.rsp.illegal);
                check_tag(out_tag, e.tag);
                check_latency(cycle_cnt, e.due);
                n_checked++;
            end
        end
    end

    initial begin
        int                fd;
        int                n_fields;
        int                n_vec;
        int                gap;
        int                wait_cycles;
        string             line;
        logic [31:0]       f_imm;
        logic [31:0]       f_f7;
        logic [31:0]       f_f3;
        logic [31:0]       f_op1;
        logic [31:0]       f_op2;
        logic [31:0]       f_res;
        logic [31:0]       f_ill;
        alu_pkg::alu_req_t r;
        expect_t           e;
        logic [TAG_W-1:0]  tag_cnt;

        in_valid  = 1'b0;
        req       = '0;
        in_tag    = '0;
        arst_n    = 1'b0;
        n_checked = 0;
        cycle_cnt = 0;
        n_vec     = 0;
        tag_cnt   = '0;
        void'($urandom(32'heecc_da3e));

        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;

        fd = $fopen("tests/alu_input.txt", "r");
        if (fd == 0) begin
            report_error("Could not open the stimulus file tests/alu_input.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() < 2 || line.substr(0, 1) == "//") begin
                continue;
            end
            n_fields = $sscanf(line, "%h %h %h %h %h %h %h",
                               f_imm, f_f7, f_f3, f_op1, f_op2, f_res, f_ill);
            if (n_fields != 7) begin
                report_error($sformatf("Malformed stimulus line: %s", line));
            end
            r.is_imm      = f_imm[0];
            r.funct7      = f_f7[6:0];
            r.funct3      = f_f3[2:0];
            r.op1         = f_op1;
            r.op2         = f_op2;
            e.rsp.result  = f_res;
            e.rsp.illegal = f_ill[0];
            e.tag         = tag_cnt;

            // Idle cycles between requests
            gap = $urandom_range(MAX_GAP, 0);
            repeat (gap) begin
                @(posedge clk);
                #DRIVE_DLY;
                in_valid = 1'b0;
            end

            @(posedge clk);
            #DRIVE_DLY;
            in_valid = 1'b1;
            req      = r;
            in_tag   = tag_cnt;
            e.due    = cycle_cnt + 2;
            exp_q.push_back(e);
            tag_cnt  = tag_cnt + TAG_W'(1);
            n_vec++;
        end
        $fclose(fd);
        @(posedge clk);
        #DRIVE_DLY;
        in_valid = 1'b0;

        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            wait_cycles++;
        end

        if (exp_q.size() != 0) begin
            report_error($sformatf("Timed out with %0d responses never returned",
                                   exp_q.size()));
        end else if (n_vec == 0) begin
            report_error("The stimulus file held no requests");
        end else begin
            $display("Checked %0d responses", n_checked);
            $display("All tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tests/alu_input.txt */
// Columns are is_imm funct7 funct3 op1 op2 result illegal
// Every field is hexadecimal
0 00 0 00000005 00000007 0000000c 0
0 00 0 ffffffff 00000001 00000000 0
0 20 0 00000000 00000001 ffffffff 0
0 20 0 80000000 00000001 7fffffff 0
1 00 0 7fffffff 00000001 80000000 0
1 7f 0 00000001 00000002 00000003 0
0 00 4 f0f0f0f0 ff00ff00 0ff00ff0 0
0 00 6 f0f0f0f0 0f0f0000 fffff0f0 0
0 00 7 f0f0f0f0 ff00ff00 f000f000 0
1 00 4 aaaaaaaa ffffffff 55555555 0
1 00 7 12345678 000000ff 00000078 0
0 00 2 ffffffff 00000001 00000001 0
0 00 3 ffffffff 00000001 00000000 0
0 00 2 00000001 ffffffff 00000000 0
0 00 3 00000001 ffffffff 00000001 0
0 00 2 80000000 7fffffff 00000001 0
1 00 3 80000000 00000001 00000000 0
0 00 1 00000001 00000024 00000010 0
0 00 1 80000001 0000001f 80000000 0
0 00 5 80000000 00000104 08000000 0
0 20 5 80000000 00000104 f8000000 0
0 20 5 7ffffff0 00000004 07ffffff 0
1 00 1 0000000f 00000008 00000f00 0
1 00 5 f0000000 0000001c 0000000f 0
1 20 5 f0000000 0000001c ffffffff 0
1 20 5 80000000 0000003f ffffffff 0
0 01 0 00000007 fffffffd ffffffeb 0
0 01 0 00010000 00010000 00000000 0
0 01 1 ffffffff ffffffff 00000000 0
0 01 1 80000000 80000000 40000000 0
0 01 1 fffffffe 00000003 ffffffff 0
0 01 3 ffffffff ffffffff fffffffe 0
0 01 3 00010000 00010000 00000001 0
0 01 2 ffffffff ffffffff ffffffff 0
0 01 2 00000002 80000000 00000001 0
0 01 2 80000000 00000002 ffffffff 0
0 01 4 00000014 00000006 00000003 0
0 01 4 ffffffec 00000006 fffffffd 0
0 01 6 ffffffec 00000006 fffffffe 0
0 01 5 ffffffec 00000006 2aaaaaa7 0
0 01 7 ffffffec 00000006 00000002 0
0 01 6 00000014 fffffffa 00000002 0
0 01 4 00000007 00000000 ffffffff 0
0 01 5 00000007 00000000 ffffffff 0
0 01 6 00000007 00000000 00000007 0
0 01 7 fffffff9 00000000 fffffff9 0
0 01 4 80000000 ffffffff 80000000 0
0 01 6 80000000 ffffffff 00000000 0
0 01 5 80000000 ffffffff 00000000 0
0 01 7 80000000 ffffffff 80000000 0
0 02 0 00000001 00000002 00000000 1
0 20 1 00000001 00000002 00000000 1
1 20 1 00000001 00000002 00000000 1
1 01 5 00000001 00000002 00000000 1
0 7f 7 ffffffff ffffffff 00000000 1

/* compile.f */
src/alu_pkg.sv
src/alu_decode.sv
src/alu_mul.sv
src/alu_div.sv
src/alu_exec.sv
src/alu_pipe_top.sv
tests/alu_pipe_assert.sv
tests/tb_alu_pipe.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_alu_pipe
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
